// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - rtl/frontend_pkg.sv
  - rtl/branch_update_if.sv
  - rtl/branch_predictor.sv
  - rtl/pc_gen.sv
  - rtl/fetch_frontend.sv
  - target: test
    files:
      - verification/fetch_checker.sv
      - verification/fetch_frontend_tb.sv

// ==== rtl/branch_predictor.sv ====
`default_nettype none

module branch_predictor (
    input  logic                     clk,
    input  logic                     rst,
    input  frontend_pkg::inst_addr_t fetch_pc,
    branch_update_if.predictor       upd,
    output logic                     pred_hit,
    output logic                     pred_taken,
    output frontend_pkg::inst_addr_t pred_target
);

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////

    // only the valid bits are reset
    logic [frontend_pkg::btb_entries-1:0] entry_valid;

    frontend_pkg::btb_tag_t   entry_tag    [frontend_pkg::btb_entries];
    frontend_pkg::inst_addr_t entry_target [frontend_pkg::btb_entries];
    frontend_pkg::sat_cnt_t   entry_cnt    [frontend_pkg::btb_entries];

    // lookup side
    frontend_pkg::btb_idx_t lookup_idx;
    frontend_pkg::btb_tag_t lookup_tag;

    // training side
    frontend_pkg::btb_idx_t upd_idx;
    frontend_pkg::btb_tag_t upd_tag;
    logic                   upd_match;
    frontend_pkg::sat_cnt_t upd_cnt;
    frontend_pkg::sat_cnt_t cnt_next;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // pc bits 5..2 pick the entry, 31..6 are compared
    assign lookup_idx = fetch_pc[frontend_pkg::tag_lsb-1:frontend_pkg::idx_lsb];
    assign lookup_tag = fetch_pc[frontend_pkg::inst_addr_bits-1:frontend_pkg::tag_lsb];

    assign pred_hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);

    // counter msb decides direction
    assign pred_taken  = pred_hit && entry_cnt[lookup_idx][1];
    assign pred_target = entry_target[lookup_idx];

    ////////////////////////////////////////
    // training
    ////////////////////////////////////////

    assign upd_idx = upd.resolve_pc[frontend_pkg::tag_lsb-1:frontend_pkg::idx_lsb];
    assign upd_tag = upd.resolve_pc[frontend_pkg::inst_addr_bits-1:frontend_pkg::tag_lsb];

    // same branch already tracked in this slot
    assign upd_match = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_tag);
    assign upd_cnt   = entry_cnt[upd_idx];

    // next counter value for the trained slot
    always_comb begin
        cnt_next = upd_cnt;
        if (!upd_match) begin
            // new or aliased branch, start weak
            if (upd.resolve_taken) begin
                cnt_next = frontend_pkg::cnt_init_taken;
            end else begin
                cnt_next = frontend_pkg::cnt_init_not_taken;
            end
        end else if (upd.resolve_taken) begin
            // count up, stop at strongly taken
            if (upd_cnt != frontend_pkg::cnt_max) begin
                cnt_next = upd_cnt + 2'd1;
            end
        end else begin
            // count down, stop at strongly not taken
            if (upd_cnt != frontend_pkg::cnt_min) begin
                cnt_next = upd_cnt - 2'd1;
            end
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (upd.resolve_valid) begin
            entry_valid[upd_idx] <= 1'b1;
        end
    end

    // tag, target and counter
    // on a tag match the tag write is a no-op, on a miss the slot is taken over
    always_ff @(posedge clk) begin
        if (upd.resolve_valid) begin
            entry_tag[upd_idx]    <= upd_tag;
            entry_target[upd_idx] <= upd.resolve_target;
            entry_cnt[upd_idx]    <= cnt_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_update_if.sv ====
`default_nettype none

interface branch_update_if;

    // resolve info from the backend
    logic                     resolve_valid;
    logic                     resolve_taken;
    frontend_pkg::inst_addr_t resolve_pc;
    frontend_pkg::inst_addr_t resolve_target;

    // misprediction flush and where to go instead
    logic                     mispredict;
    frontend_pkg::inst_addr_t redirect_pc;

    // drive side, fed from the top level ports
    modport backend (
        output resolve_valid, resolve_pc, resolve_target, resolve_taken,
        output mispredict, redirect_pc
    );

    // btb training
    modport predictor (
        input resolve_valid, resolve_pc, resolve_target, resolve_taken
    );

    // pc redirect
    modport pc (
        input mispredict, redirect_pc
    );

endinterface

`default_nettype wire

// ==== rtl/fetch_frontend.sv ====
`default_nettype none

module fetch_frontend (
    input  logic                     clk,
    input  logic                     rst,
    // pipeline control
    input  logic                     stall,
    input  logic                     pause,
    input  logic                     exception_flush,
    input  frontend_pkg::inst_addr_t exception_pc,
    input  logic                     interrupt,
    // branch resolve from the backend
    input  logic                     resolve_valid,
    input  frontend_pkg::inst_addr_t resolve_pc,
    input  frontend_pkg::inst_addr_t resolve_target,
    input  logic                     resolve_taken,
    input  logic                     mispredict,
    input  frontend_pkg::inst_addr_t redirect_pc,
    // to the instruction memory and decode
    output frontend_pkg::inst_addr_t fetch_pc,
    output logic                     inst_en,
    output logic                     fetch_exc_valid,
    output frontend_pkg::exc_code_t  fetch_exc_code
);

    ////////////////////////////////////////
    // resolve bus
    ////////////////////////////////////////

    branch_update_if upd_bus ();

    assign upd_bus.resolve_valid  = resolve_valid;
    assign upd_bus.resolve_pc     = resolve_pc;
    assign upd_bus.resolve_target = resolve_target;
    assign upd_bus.resolve_taken  = resolve_taken;
    assign upd_bus.mispredict     = mispredict;
    assign upd_bus.redirect_pc    = redirect_pc;

    // prediction into the pc generator
    logic                     pred_taken;
    frontend_pkg::inst_addr_t pred_target;

    ////////////////////////////////////////
    // btb
    ////////////////////////////////////////

    // hit alone is already folded into pred_taken
    branch_predictor branch_predictor_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_pc    (fetch_pc),
        .upd         (upd_bus.predictor),
        .pred_hit    (),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    ////////////////////////////////////////
    // fetch pc
    ////////////////////////////////////////

    pc_gen pc_gen_inst (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .pause           (pause),
        .exception_flush (exception_flush),
        .exception_pc    (exception_pc),
        .interrupt       (interrupt),
        .upd             (upd_bus.pc),
        .pred_taken      (pred_taken),
        .pred_target     (pred_target),
        .fetch_pc        (fetch_pc),
        .inst_en         (inst_en),
        .fetch_exc_valid (fetch_exc_valid),
        .fetch_exc_code  (fetch_exc_code)
    );

endmodule

`default_nettype wire

// ==== rtl/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    ////////////////////////////////////////
    // address types
    ////////////////////////////////////////

    localparam int inst_addr_bits = 32;

    // instruction address
    typedef logic [inst_addr_bits-1:0] inst_addr_t;

    // first fetch address out of reset
    localparam inst_addr_t reset_pc = 32'h100;

    // sequential fetch step, one instruction
    localparam inst_addr_t pc_step = 32'd4;

    ////////////////////////////////////////
    // btb geometry
    ////////////////////////////////////////

    localparam int btb_index_bits = 4;
    localparam int btb_entries    = 1 << btb_index_bits;

    // index sits just above the word offset
    localparam int idx_lsb = 2;
    localparam int tag_lsb = idx_lsb + btb_index_bits;

    typedef logic [btb_index_bits-1:0]         btb_idx_t;
    typedef logic [inst_addr_bits-tag_lsb-1:0] btb_tag_t;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] sat_cnt_t;

    localparam sat_cnt_t cnt_max            = 2'd3;
    localparam sat_cnt_t cnt_min            = 2'd0;
    // weakly taken / weakly not taken on allocation
    localparam sat_cnt_t cnt_init_taken     = 2'd2;
    localparam sat_cnt_t cnt_init_not_taken = 2'd1;

    ////////////////////////////////////////
    // fetch exception codes
    ////////////////////////////////////////

    typedef logic [5:0] exc_code_t;

    localparam exc_code_t exc_nop  = 6'd0;
    localparam exc_code_t exc_int  = 6'd1;
    // address error on fetch
    localparam exc_code_t exc_adef = 6'd8;

endpackage

`default_nettype wire

// ==== rtl/pc_gen.sv ====
`default_nettype none

module pc_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     pause,
    input  logic                     exception_flush,
    input  frontend_pkg::inst_addr_t exception_pc,
    input  logic                     interrupt,
    branch_update_if.pc              upd,
    input  logic                     pred_taken,
    input  frontend_pkg::inst_addr_t pred_target,
    output frontend_pkg::inst_addr_t fetch_pc,
    output logic                     inst_en,
    output logic                     fetch_exc_valid,
    output frontend_pkg::exc_code_t  fetch_exc_code
);

    frontend_pkg::inst_addr_t pc_next;
    // interrupt sampled once per cycle
    logic                     int_flag;

    ////////////////////////////////////////
    // next pc selection
    ////////////////////////////////////////

    always_comb begin
        // exception flush wins over everything but reset
        if (exception_flush) begin
            pc_next = exception_pc;
        end else if (pause) begin
            pc_next = fetch_pc;
        // branch fix overrides a plain stall
        end else if (upd.mispredict) begin
            pc_next = upd.redirect_pc;
        end else if (stall) begin
            pc_next = fetch_pc;
        end else if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = fetch_pc + frontend_pkg::pc_step;
        end
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    // fetch pc
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= frontend_pkg::reset_pc;
        end else begin
            fetch_pc <= pc_next;
        end
    end

    // interrupt flag, one cycle behind the level
    always_ff @(posedge clk) begin
        if (rst) begin
            int_flag <= 1'b0;
        end else begin
            int_flag <= interrupt;
        end
    end

    // imem read enable, low in reset and high afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_en <= 1'b0;
        end else begin
            inst_en <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // fetch exception tag
    ////////////////////////////////////////

    // follows fetch_pc in the same cycle
    always_comb begin
        if (int_flag) begin
            fetch_exc_code = frontend_pkg::exc_int;
        end else if (fetch_pc[1:0] != 2'b00) begin
            // misaligned fetch address
            fetch_exc_code = frontend_pkg::exc_adef;
        end else begin
            fetch_exc_code = frontend_pkg::exc_nop;
        end
    end

    assign fetch_exc_valid = (fetch_exc_code != frontend_pkg::exc_nop);

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/frontend_pkg.sv
rtl/branch_update_if.sv
rtl/branch_predictor.sv
rtl/pc_gen.sv
rtl/fetch_frontend.sv
verification/fetch_checker.sv
verification/fetch_frontend_tb.sv

// ==== verification/fetch_checker.sv ====
`default_nettype none

// independent model of the btb and the next pc rules
module fetch_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     pause,
    input  logic                     exception_flush,
    input  frontend_pkg::inst_addr_t exception_pc,
    input  logic                     interrupt,
    input  logic                     resolve_valid,
    input  frontend_pkg::inst_addr_t resolve_pc,
    input  frontend_pkg::inst_addr_t resolve_target,
    input  logic                     resolve_taken,
    input  logic                     mispredict,
    input  frontend_pkg::inst_addr_t redirect_pc,
    input  frontend_pkg::inst_addr_t fetch_pc,
    input  logic                     inst_en,
    input  logic                     fetch_exc_valid,
    input  frontend_pkg::exc_code_t  fetch_exc_code,
    input  logic [127:0]             test_name,
    output int                       pc_errors,
    output int                       en_errors,
    output int                       exc_errors,
    output int                       checks
);

    // model btb, slot picked by pc[5:2], tag is pc[31:6]
    logic                     m_valid  [16];
    logic [25:0]              m_tag    [16];
    frontend_pkg::inst_addr_t m_target [16];
    int                       m_cnt    [16];

    // model pc side
    frontend_pkg::inst_addr_t m_pc;
    logic                     m_int;
    logic                     m_en;
    logic                     model_ready;
    // name of the line whose result shows next
    logic [127:0]             checked_name;

    initial begin
        pc_errors   = 0;
        en_errors   = 0;
        exc_errors  = 0;
        checks      = 0;
        model_ready = 1'b0;
    end

    ////////////////////////////////////////
    // model step at the sampling edge
    ////////////////////////////////////////

    always @(posedge clk) begin
        logic [3:0]               l_idx;
        logic [3:0]               r_idx;
        logic                     l_taken;
        frontend_pkg::inst_addr_t l_target;
        checked_name = test_name;
        if (rst) begin
            m_pc  = frontend_pkg::reset_pc;
            m_int = 1'b0;
            m_en  = 1'b0;
            for (int i = 0; i < 16; i++) begin
                m_valid[i] = 1'b0;
            end
            model_ready = 1'b1;
        end else begin
            // lookup sees the btb as it was before this edge
            l_idx    = m_pc[5:2];
            l_taken  = m_valid[l_idx] && (m_tag[l_idx] == m_pc[31:6]) && (m_cnt[l_idx] >= 2);
            l_target = m_target[l_idx];
            // training
            r_idx = resolve_pc[5:2];
            if (resolve_valid) begin
                if (m_valid[r_idx] && (m_tag[r_idx] == resolve_pc[31:6])) begin
                    // same branch, saturate at 0 and 3
                    if (resolve_taken) begin
                        m_cnt[r_idx] = (m_cnt[r_idx] == 3) ? 3 : m_cnt[r_idx] + 1;
                    end else begin
                        m_cnt[r_idx] = (m_cnt[r_idx] == 0) ? 0 : m_cnt[r_idx] - 1;
                    end
                end else begin
                    // slot changes owner, weak start
                    m_tag[r_idx] = resolve_pc[31:6];
                    m_cnt[r_idx] = resolve_taken ? 2 : 1;
                end
                m_target[r_idx] = resolve_target;
                m_valid[r_idx]  = 1'b1;
            end
            // flush, pause, mispredict, stall, prediction, +4
            if (exception_flush) begin
                m_pc = exception_pc;
            end else if (!pause) begin
                if (mispredict) begin
                    m_pc = redirect_pc;
                end else if (!stall) begin
                    m_pc = l_taken ? l_target : m_pc + 32'd4;
                end
            end
            m_int = interrupt;
            m_en  = 1'b1;
        end
    end

    ////////////////////////////////////////
    // compare mid cycle, outputs settled
    ////////////////////////////////////////

    always @(negedge clk) begin
        frontend_pkg::exc_code_t exp_code;
        if (model_ready) begin
            // interrupt first, then misaligned pc
            if (m_int) begin
                exp_code = frontend_pkg::exc_int;
            end else if (m_pc[1:0] != 2'b00) begin
                exp_code = frontend_pkg::exc_adef;
            end else begin
                exp_code = frontend_pkg::exc_nop;
            end
            checks++;
            if (fetch_pc !== m_pc) begin
                pc_errors++;
                $display("Fail %0s fetch_pc expected %h actual %h", checked_name, m_pc, fetch_pc);
            end
            if (inst_en !== m_en) begin
                en_errors++;
                $display("Fail %0s inst_en expected %b actual %b", checked_name, m_en, inst_en);
            end
            if (fetch_exc_code !== exp_code) begin
                exc_errors++;
                $display("Fail %0s fetch_exc_code expected %h actual %h",
                         checked_name, exp_code, fetch_exc_code);
            end
            if (fetch_exc_valid !== (exp_code != frontend_pkg::exc_nop)) begin
                exc_errors++;
                $display("Fail %0s fetch_exc_valid expected %b actual %b",
                         checked_name, exp_code != frontend_pkg::exc_nop, fetch_exc_valid);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/fetch_frontend_tb.sv ====
`default_nettype none

module fetch_frontend_tb;

    localparam int half_period  = 4;
    localparam int reset_cycles = 16;
    localparam int slack_cycles = 20;
    localparam int max_lines    = 256;
    // stall pause flush exc_pc int rv rpc rtgt rtaken mp redirect
    localparam int drive_bits   = 135;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     stall;
    logic                     pause;
    logic                     exception_flush;
    frontend_pkg::inst_addr_t exception_pc;
    logic                     interrupt;
    logic                     resolve_valid;
    frontend_pkg::inst_addr_t resolve_pc;
    frontend_pkg::inst_addr_t resolve_target;
    logic                     resolve_taken;
    logic                     mispredict;
    frontend_pkg::inst_addr_t redirect_pc;
    frontend_pkg::inst_addr_t fetch_pc;
    logic                     inst_en;
    logic                     fetch_exc_valid;
    frontend_pkg::exc_code_t  fetch_exc_code;

    // checker side
    logic [127:0]             test_name;
    int                       pc_errors;
    int                       en_errors;
    int                       exc_errors;
    int                       checks;

    // parsed stim with one packed input vector per cycle
    logic [127:0]          stim_name [max_lines];
    logic [drive_bits-1:0] stim_bits [max_lines];
    int                    n_lines      = 0;
    int                    setup_errors = 0;

    // run length guard
    int                    cycle_count  = 0;
    int                    cycle_limit  = 0;
    logic                  limit_ready  = 1'b0;

    fetch_frontend fetch_frontend_inst (.*);
    fetch_checker  checker_inst (.*);

    always #half_period clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // all dut inputs but clk and rst in stim column order
    task automatic drive_inputs(input logic [drive_bits-1:0] bits);
        {stall, pause, exception_flush, exception_pc, interrupt, resolve_valid,
         resolve_pc, resolve_target, resolve_taken, mispredict, redirect_pc} = bits;
    endtask

    // comment lines never scan into twelve fields
    task automatic load_stim();
        int               fd;
        int               got;
        logic [8*256-1:0] line_buf;
        logic [127:0]     name_tmp;
        logic [31:0]      v [11];
        fd = $fopen("verification/fetch_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/fetch_stim.txt for reading");
            setup_errors++;
        end else begin
            while (!$feof(fd) && n_lines < max_lines) begin
                line_buf = '0;
                got      = $fgets(line_buf, fd);
                got      = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h", name_tmp,
                                   v[0], v[1], v[2], v[3], v[4], v[5],
                                   v[6], v[7], v[8], v[9], v[10]);
                if (got == 12) begin
                    stim_name[n_lines] = name_tmp;
                    stim_bits[n_lines] = {v[0][0], v[1][0], v[2][0], v[3], v[4][0], v[5][0],
                                          v[6], v[7], v[8][0], v[9][0], v[10]};
                    n_lines++;
                end
            end
            $fclose(fd);
        end
        if (n_lines == 0) begin
            $display("no stimulus lines were read, nothing was tested");
            setup_errors++;
        end
    endtask

    initial begin
        rst       = 1'b1;
        test_name = "reset";
        drive_inputs('0);
        load_stim();
        // reset, one cycle per line, then slack
        cycle_limit = reset_cycles + n_lines + slack_cycles;
        limit_ready = 1'b1;

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            test_name = stim_name[i];
            drive_inputs(stim_bits[i]);
            @(negedge clk);
        end
        // let the last line reach the compare
        test_name = "idle";
        drive_inputs('0);
        repeat (2) @(negedge clk);
        // step past the last compare edge
        @(posedge clk);

        $display("errors: fetch_pc %0d, inst_en %0d, exception %0d, setup %0d in %0d checks",
                 pc_errors, en_errors, exc_errors, setup_errors, checks);
        if (pc_errors + en_errors + exc_errors + setup_errors == 0 && checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_ready === 1'b1);
        while (cycle_count < cycle_limit) @(posedge clk);
        $display("timeout: the run was still going after %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/fetch_stim.txt ====
# name stall pause exception_flush exception_pc interrupt resolve_valid resolve_pc
# resolve_target resolve_taken mispredict redirect_pc, values in hex, one line per cycle
reset_seq      0 0 0 0   0 0 0   0   0 0 0
reset_seq      0 0 0 0   0 0 0   0   0 0 0
hold_stall     1 0 0 0   0 0 0   0   0 0 0
hold_pause     0 1 0 0   0 0 0   0   0 0 0
pause_vs_mp    0 1 0 0   0 0 0   0   0 1 200
flush_vs_pause 0 1 1 300 0 0 0   0   0 0 0
redirect_mp    0 0 0 0   0 0 0   0   0 1 400
flush_vs_mp    0 0 1 500 0 0 0   0   0 1 600
mp_vs_stall    1 0 0 0   0 1 704 800 1 1 700
pred_taken     0 0 0 0   0 0 0   0   0 0 0
pred_taken     0 0 0 0   0 1 704 800 1 0 0
pred_train_nt  0 0 0 0   0 1 704 800 0 1 704
pred_train_nt  0 0 0 0   0 1 704 800 0 1 704
pred_train_nt  0 0 0 0   0 0 0   0   0 0 0
pred_alias     0 0 0 0   0 1 704 800 1 1 1704
pred_alias     0 0 0 0   0 0 0   0   0 0 0
pred_stall     0 0 0 0   0 0 0   0   0 1 704
pred_stall     1 0 0 0   0 0 0   0   0 0 0
pred_stall     0 0 0 0   0 0 0   0   0 0 0
exc_adef       0 0 1 902 0 0 0   0   0 0 0
exc_int        0 0 0 0   1 0 0   0   0 1 a00
exc_int        0 0 1 b01 1 0 0   0   0 0 0
exc_int        0 0 0 0   0 0 0   0   0 0 0
exc_adef       0 0 0 0   0 0 0   0   0 1 c00
exc_adef       0 0 0 0   0 0 0   0   0 0 0
